// ==== logic/div_defines.svh ====
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// register width of the integer pipeline
`define DIV_XLEN 64

// add/subtract steps, one per extended operand bit
`define DIV_STEPS64 65
`define DIV_STEPS32 33

`endif

// ==== logic/div_pkg.sv ====
`include "div_defines.svh"

package div_pkg;

  typedef logic [`DIV_XLEN-1:0] xlen_t;  // register value
  typedef logic [`DIV_XLEN:0]   ext_t;   // value plus extension bit

  typedef enum logic [1:0] {
    OP_DIV  = 2'b00,
    OP_DIVU = 2'b01,
    OP_REM  = 2'b10,
    OP_REMU = 2'b11
  } div_op_e;

  typedef struct packed {
    div_op_e op;
    logic    word;      // 32-bit W form
    xlen_t   dividend;  // rs1
    xlen_t   divisor;   // rs2
  } div_req_t;

  typedef struct packed {
    logic is_signed;
    logic word;
  } div_ctrl_t;

  typedef struct packed {
    logic  want_rem;
    logic  word;
    logic  special;      // result known without the core
    xlen_t special_val;
  } div_fmt_t;

  typedef struct packed {
    xlen_t quot;
    xlen_t rem;
  } div_res_t;

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_COUNT,
    CORE_CORRECT
  } core_state_e;

endpackage

// ==== logic/div_request_stage.sv ====
`include "div_defines.svh"

module div_request_stage
  import div_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid_i,
  input  div_req_t  req_i,
  input  logic      resp_valid_i,
  output logic      busy_o,
  output logic      start_o,
  output div_ctrl_t ctrl_o,
  output xlen_t     dividend_o,
  output xlen_t     divisor_o,
  output div_fmt_t  fmt_o,
  output logic      bypass_o
);

  logic     accept;
  logic     is_signed, want_rem;
  logic     div_zero, overflow, special;
  xlen_t    special_val;
  logic     busy_q;
  logic     bypass_arm_q, bypass_q;
  div_fmt_t fmt_q;

  always_comb begin
    is_signed = (req_i.op == OP_DIV) || (req_i.op == OP_REM);
    want_rem  = (req_i.op == OP_REM) || (req_i.op == OP_REMU);

    if (req_i.word) begin
      div_zero = (req_i.divisor[31:0] == 32'h0);
      overflow = is_signed && (req_i.dividend[31:0] == 32'h8000_0000)
                 && (req_i.divisor[31:0] == 32'hffff_ffff);
    end else begin
      div_zero = (req_i.divisor == '0);
      overflow = is_signed && (req_i.dividend == {1'b1, {(`DIV_XLEN-1){1'b0}}})
                 && (req_i.divisor == '1);
    end
    special = div_zero || overflow;

    // RISC-V defined results, formatter sign-extends W forms
    if (div_zero) begin
      special_val = want_rem ? req_i.dividend : '1;
    end else begin
      special_val = want_rem ? '0 : req_i.dividend;  // overflow
    end
  end

  assign accept  = req_valid_i && !busy_q;  // requests while busy are dropped
  assign start_o = accept && !special;

  assign ctrl_o.is_signed = is_signed;
  assign ctrl_o.word      = req_i.word;
  assign dividend_o       = req_i.dividend;
  assign divisor_o        = req_i.divisor;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q       <= 1'b0;
      bypass_arm_q <= 1'b0;
      bypass_q     <= 1'b0;
    end else begin
      bypass_arm_q <= accept && special;
      bypass_q     <= bypass_arm_q;  // lands one cycle after accept
      if (accept) begin
        busy_q <= 1'b1;
      end else if (resp_valid_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // held for the whole operation
  always_ff @(posedge clk) begin
    if (accept) begin
      fmt_q.want_rem    <= want_rem;
      fmt_q.word        <= req_i.word;
      fmt_q.special     <= special;
      fmt_q.special_val <= special_val;
    end
  end

  assign busy_o   = busy_q;
  assign fmt_o    = fmt_q;
  assign bypass_o = bypass_q;

  start_quiet_while_busy: assert property (
    @(posedge clk) disable iff (rst) busy_q |-> !start_o);

  // a response must belong to an accepted request
  resp_only_when_busy: assert property (
    @(posedge clk) disable iff (rst) resp_valid_i |-> busy_q);

endmodule

// ==== logic/div_nonrestoring_core.sv ====
`include "div_defines.svh"

module div_nonrestoring_core
  import div_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start_i,
  input  div_ctrl_t ctrl_i,
  input  xlen_t     dividend_i,
  input  xlen_t     divisor_i,
  output logic      done_o,
  output div_res_t  res_o
);

  localparam int CNT_W = $clog2(`DIV_STEPS64 + 1);
  localparam int SR_W  = 2 * (`DIV_XLEN + 1);  // partial remainder and quotient
  localparam int HALF  = `DIV_XLEN / 2;

  core_state_e     state_q;
  logic            done_q;
  logic            word_q;
  logic            z_sign_q;  // dividend sign, for the correction
  logic [SR_W-1:0] s_q;
  ext_t            d_q, d_neg_q;
  logic [CNT_W-1:0] cnt_q;
  div_res_t        res_q;

  logic            sgn64_z, sgn64_d, sgn32_z, sgn32_d;
  ext_t            d_ext, d_neg;
  logic [SR_W-1:0] s_init;

  logic            s_sign, add_d, q_bit;
  ext_t            d_sel;
  ext_t            hi64;
  logic [HALF:0]   hi32;
  logic [SR_W-1:0] s_next;

  ext_t            rem_raw, rem_fix;
  logic            need_fix;
  xlen_t           q_base, q_adj, q_fix;

  // operand extension, one extra bit so DIV and DIVU share the datapath
  always_comb begin
    sgn64_z = ctrl_i.is_signed & dividend_i[`DIV_XLEN-1];
    sgn64_d = ctrl_i.is_signed & divisor_i[`DIV_XLEN-1];
    sgn32_z = ctrl_i.is_signed & dividend_i[HALF-1];
    sgn32_d = ctrl_i.is_signed & divisor_i[HALF-1];

    if (ctrl_i.word) begin
      d_ext  = {{(HALF+1){sgn32_d}}, divisor_i[HALF-1:0]};
      s_init = {{`DIV_XLEN{1'b0}}, {(HALF+2){sgn32_z}}, dividend_i[HALF-1:0]};
    end else begin
      d_ext  = {sgn64_d, divisor_i};
      s_init = {{(`DIV_XLEN+2){sgn64_z}}, dividend_i};
    end
    d_neg = ~d_ext + 1'b1;
  end

  // one nonrestoring step
  always_comb begin
    s_sign = word_q ? s_q[2*HALF+1] : s_q[SR_W-1];
    add_d  = s_sign ^ d_q[`DIV_XLEN];  // signs differ, add the divisor
    d_sel  = add_d ? d_q : d_neg_q;
    q_bit  = ~add_d;

    hi64 = s_q[SR_W-2:`DIV_XLEN] + d_sel;
    hi32 = s_q[`DIV_XLEN:HALF] + d_sel[HALF:0];

    if (word_q) begin
      s_next = {{`DIV_XLEN{1'b0}}, hi32, s_q[HALF-1:0], q_bit};
    end else begin
      s_next = {hi64, s_q[`DIV_XLEN-1:0], q_bit};
    end
  end

  // final correction of quotient and remainder
  always_comb begin
    if (word_q) begin
      rem_raw = {{HALF{s_q[2*HALF+1]}}, s_q[2*HALF+1:HALF+1]};
      q_base  = {{HALF{1'b0}}, s_q[HALF-2:0], 1'b1};
    end else begin
      rem_raw = s_q[SR_W-1:`DIV_XLEN+1];
      q_base  = {s_q[`DIV_XLEN-2:0], 1'b1};
    end

    need_fix = ((rem_raw[`DIV_XLEN] ^ z_sign_q) && (rem_raw != '0))
               || (rem_raw == d_q) || (rem_raw == d_neg_q);

    if (!need_fix) begin
      q_adj = '0;
    end else if (add_d) begin
      q_adj = '1;  // minus one
    end else begin
      q_adj = xlen_t'(1);
    end

    q_fix   = q_base + q_adj;
    rem_fix = rem_raw + (need_fix ? d_sel : '0);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= CORE_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        CORE_IDLE: begin
          if (start_i) begin
            state_q <= CORE_COUNT;
          end
        end
        CORE_COUNT: begin
          if (cnt_q == '0) begin
            state_q <= CORE_CORRECT;
          end
        end
        CORE_CORRECT: begin
          state_q <= CORE_IDLE;
          done_q  <= 1'b1;
        end
        default: begin
          state_q <= CORE_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == CORE_IDLE && start_i) begin
      word_q   <= ctrl_i.word;
      z_sign_q <= ctrl_i.word ? sgn32_z : sgn64_z;
      s_q      <= s_init;
      d_q      <= d_ext;
      d_neg_q  <= d_neg;
      cnt_q    <= ctrl_i.word ? CNT_W'(`DIV_STEPS32) : CNT_W'(`DIV_STEPS64);
    end else if (state_q == CORE_COUNT && cnt_q != '0) begin
      s_q   <= s_next;
      cnt_q <= cnt_q - 1'b1;
    end else if (state_q == CORE_CORRECT) begin
      if (word_q) begin
        res_q.quot <= {{HALF{1'b0}}, q_fix[HALF-1:0]};
        res_q.rem  <= {{HALF{1'b0}}, rem_fix[HALF-1:0]};
      end else begin
        res_q.quot <= q_fix;
        res_q.rem  <= rem_fix[`DIV_XLEN-1:0];
      end
    end
  end

  assign done_o = done_q;
  assign res_o  = res_q;

  done_single_pulse: assert property (
    @(posedge clk) disable iff (rst) done_q |=> !done_q);

  // the request stage must not start a second divide
  start_only_idle: assert property (
    @(posedge clk) disable iff (rst) start_i |-> state_q == CORE_IDLE);

endmodule

// ==== logic/div_result_format.sv ====
module div_result_format
  import div_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     core_done_i,
  input  div_res_t res_i,
  input  div_fmt_t fmt_i,
  input  logic     bypass_i,
  output logic     resp_valid_o,
  output xlen_t    resp_data_o
);

  logic  fire;
  xlen_t sel;
  xlen_t shaped;
  logic  resp_valid_q;
  xlen_t resp_data_q;

  assign fire = core_done_i || bypass_i;

  always_comb begin
    if (fmt_i.special) begin
      sel = fmt_i.special_val;
    end else if (fmt_i.want_rem) begin
      sel = res_i.rem;
    end else begin
      sel = res_i.quot;
    end

    // W forms return a sign-extended 32-bit result
    if (fmt_i.word) begin
      shaped = {{32{sel[31]}}, sel[31:0]};
    end else begin
      shaped = sel;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= fire;  // one-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      resp_data_q <= shaped;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;

  // special ops never reach the core
  no_done_with_bypass: assert property (
    @(posedge clk) disable iff (rst) core_done_i |-> !bypass_i && !fmt_i.special);

  bypass_is_special: assert property (
    @(posedge clk) disable iff (rst) bypass_i |-> fmt_i.special);

endmodule

// ==== logic/div_unit_top.sv ====
module div_unit_top
  import div_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid_i,
  input  div_req_t req_i,
  output logic     busy_o,
  output logic     resp_valid_o,
  output xlen_t    resp_data_o
);

  logic      core_start;
  div_ctrl_t core_ctrl;
  xlen_t     core_dividend, core_divisor;
  logic      core_done;
  div_res_t  core_res;
  div_fmt_t  fmt;
  logic      bypass;

  div_request_stage div_request_stage_i (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .resp_valid_i (resp_valid_o),  // response frees the unit
    .busy_o       (busy_o),
    .start_o      (core_start),
    .ctrl_o       (core_ctrl),
    .dividend_o   (core_dividend),
    .divisor_o    (core_divisor),
    .fmt_o        (fmt),
    .bypass_o     (bypass)
  );

  div_nonrestoring_core div_nonrestoring_core_i (
    .clk        (clk),
    .rst        (rst),
    .start_i    (core_start),
    .ctrl_i     (core_ctrl),
    .dividend_i (core_dividend),
    .divisor_i  (core_divisor),
    .done_o     (core_done),
    .res_o      (core_res)
  );

  div_result_format div_result_format_i (
    .clk          (clk),
    .rst          (rst),
    .core_done_i  (core_done),
    .res_i        (core_res),
    .fmt_i        (fmt),
    .bypass_i     (bypass),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o)
  );

endmodule

// ==== dv/div_unit_tb.sv ====
module div_unit_tb
  import div_pkg::*;
();

  localparam int RESP_TIMEOUT = 200;

  logic     clk;
  logic     rst;
  logic     req_valid_i;
  div_req_t req_i;
  logic     busy_o;
  logic     resp_valid_o;
  xlen_t    resp_data_o;

  logic [15:0] lfsr_q;
  int          cycle_cnt;
  int          acc_cycle;  // cycle of the accepting edge
  int          exp_lat;
  xlen_t       exp_data;
  logic        pending;    // accepted, response not yet seen
  int          op_cnt, resp_cnt, err_cnt, test_cnt;

  div_unit_top div_unit_top_i (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .busy_o       (busy_o),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  data_check: assert property (
    @(posedge clk) disable iff (rst) resp_valid_o |-> resp_data_o == exp_data)
    else begin
      err_cnt++;
      $display("mismatch at %0t: result %h, expected %h", $time, $sampled(resp_data_o),
               $sampled(exp_data));
    end

  latency_check: assert property (
    @(posedge clk) disable iff (rst) resp_valid_o |-> cycle_cnt - acc_cycle == exp_lat)
    else begin
      err_cnt++;
      $display("mismatch at %0t: latency %0d, expected %0d", $time,
               $sampled(cycle_cnt) - $sampled(acc_cycle), $sampled(exp_lat));
    end

  resp_check: assert property (
    @(posedge clk) disable iff (rst) resp_valid_o |-> pending)
    else begin
      err_cnt++;
      $display("a response arrived at %0t with no request outstanding", $time);
    end

  busy_check: assert property (
    @(posedge clk) disable iff (rst) pending |-> busy_o)
    else begin
      err_cnt++;
      $display("busy was low at %0t while a request was outstanding", $time);
    end

  release_check: assert property (
    @(posedge clk) disable iff (rst) resp_valid_o |=> !busy_o && !resp_valid_o)
    else begin
      err_cnt++;
      $display("busy or response valid still high at %0t, one cycle after a response", $time);
    end

  reset_check: assert property (
    @(posedge clk) $fell(rst) |-> !busy_o && !resp_valid_o)
    else begin
      err_cnt++;
      $display("unit not idle when reset was released");
    end

  // galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic rand_bit();
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
    return lfsr_q[0];
  endfunction

  function automatic xlen_t rand_bits(int n);
    xlen_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic div_op_e rand_op();
    logic [1:0] v;
    v[1] = rand_bit();
    v[0] = rand_bit();
    return div_op_e'(v);
  endfunction

  function automatic logic is_special(div_op_e op, logic word, xlen_t a, xlen_t b);
    logic sgn;
    sgn = (op == OP_DIV) || (op == OP_REM);
    if (word) begin
      return (b[31:0] == 0) || (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == '1);
    end
    return (b == 0) || (sgn && a == 64'h8000_0000_0000_0000 && b == '1);
  endfunction

  // RISC-V M rules, division truncates toward zero
  function automatic xlen_t model_result(div_op_e op, logic word, xlen_t a, xlen_t b);
    logic        sgn, rem;
    logic [31:0] r32;
    xlen_t       r;
    sgn = (op == OP_DIV) || (op == OP_REM);
    rem = (op == OP_REM) || (op == OP_REMU);
    if (word) begin
      if (b[31:0] == 0) begin
        r32 = rem ? a[31:0] : 32'hffff_ffff;
      end else if (is_special(op, word, a, b)) begin
        r32 = rem ? 32'h0 : a[31:0];  // signed overflow
      end else if (sgn) begin
        r32 = rem ? $signed(a[31:0]) % $signed(b[31:0]) : $signed(a[31:0]) / $signed(b[31:0]);
      end else begin
        r32 = rem ? a[31:0] % b[31:0] : a[31:0] / b[31:0];
      end
      return {{32{r32[31]}}, r32};
    end
    if (b == 0) begin
      r = rem ? a : '1;
    end else if (is_special(op, word, a, b)) begin
      r = rem ? '0 : a;
    end else if (sgn) begin
      r = rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    end else begin
      r = rem ? a % b : a / b;
    end
    return r;
  endfunction

  task automatic finish_run();
    $display("tests %0d, ops %0d, responses %0d, errors %0d", test_cnt, op_cnt, resp_cnt,
             err_cnt);
    if (err_cnt == 0 && resp_cnt == op_cnt) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic send_req(div_op_e op, logic word, xlen_t a, xlen_t b);
    int waited;
    waited = 0;
    while (busy_o && waited < RESP_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (busy_o) begin
      err_cnt++;
      $display("unit stayed busy for %0d cycles, request could not be sent", RESP_TIMEOUT);
      finish_run();
    end else begin
      req_i.op       = op;
      req_i.word     = word;
      req_i.dividend = a;
      req_i.divisor  = b;
      exp_data = model_result(op, word, a, b);
      exp_lat  = is_special(op, word, a, b) ? 2 : (word ? 36 : 68);
      req_valid_i = 1'b1;
      @(posedge clk);
      #1;
      req_valid_i = 1'b0;
      acc_cycle   = cycle_cnt;
      pending     = 1'b1;
      op_cnt++;
    end
  endtask

  task automatic wait_resp();
    int waited;
    waited = 0;
    while (!resp_valid_o && waited < RESP_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (resp_valid_o) begin
      resp_cnt++;
      @(posedge clk);  // let the checks sample this response
      #1;
      pending = 1'b0;
    end else begin
      err_cnt++;
      $display("no response arrived within %0d cycles", RESP_TIMEOUT);
      finish_run();
    end
  endtask

  task automatic run_op(div_op_e op, logic word, xlen_t a, xlen_t b);
    send_req(op, word, a, b);
    wait_resp();
  endtask

  // request while busy, must be dropped
  task automatic pulse_ignored(xlen_t a, xlen_t b);
    req_i.op       = OP_REMU;
    req_i.dividend = a;
    req_i.divisor  = b;
    req_valid_i    = 1'b1;
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic report_test(string name);
    test_cnt++;
    $display("test %0s finished, ops %0d, errors %0d", name, op_cnt, err_cnt);
  endtask

  initial begin
    div_op_e ops [4] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    xlen_t   edge_a [8] = '{64'sd12, -64'sd12, 64'sd7, -64'sd7, 64'sd7, -64'sd7, -64'sd12, 64'sd3};
    xlen_t   edge_b [8] = '{-64'sd3, 64'sd4, 64'sd7, 64'sd7, -64'sd7, -64'sd7, -64'sd4, 64'sd5};
    xlen_t   a, b;
    logic [1:0] mode;
    clk = 1'b0;
    rst = 1'b1;
    req_valid_i = 1'b0;
    req_i = '0;
    lfsr_q = 16'd28569;
    cycle_cnt = 0;
    acc_cycle = 0;
    exp_lat = 0;
    exp_data = '0;
    pending = 1'b0;
    op_cnt = 0;
    resp_cnt = 0;
    err_cnt = 0;
    test_cnt = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    repeat (24) begin
      a = rand_bits(64);
      b = rand_bits(64);
      mode = 2'(rand_bits(2));
      case (mode)
        2'd1: b = b & 64'hff;
        2'd2: begin
          a = a & 64'hffff;
          b = -(b & 64'hff);
        end
        2'd3: begin
          a = -(a & 64'hffff_ffff);
          b = b & 64'hfff;
        end
        default: ;
      endcase
      run_op(rand_op(), 1'b0, a, b);
    end
    report_test("random_64bit");

    repeat (24) begin
      a = rand_bits(64);
      b = rand_bits(64);
      mode = 2'(rand_bits(2));
      case (mode)
        2'd1: a = a | 64'h8000_0000;
        2'd2: b = b | 64'hffff_ff00;  // small negative word divisor
        2'd3: begin
          a = a | 64'h8000_0000;
          b = b & 64'hffff_ffff_0000_00ff;
        end
        default: ;
      endcase
      run_op(rand_op(), 1'b1, a, b);
    end
    report_test("random_word");

    for (int k = 0; k < 4; k++) begin
      run_op(ops[k], 1'b0, rand_bits(64), 64'h0);
      run_op(ops[k], 1'b1, rand_bits(64) | 64'h8000_0000, rand_bits(64) & 64'hffff_ffff_0000_0000);
    end
    report_test("divide_by_zero");

    for (int k = 0; k < 4; k++) begin
      run_op(ops[k], 1'b0, 64'h8000_0000_0000_0000, '1);
      run_op(ops[k], 1'b1, rand_bits(64) & 64'hffff_ffff_0000_0000 | 64'h8000_0000,
             rand_bits(64) | 64'hffff_ffff);
    end
    report_test("signed_overflow");

    send_req(OP_DIV, 1'b0, rand_bits(64), rand_bits(16) | 64'h1);
    repeat (5) begin
      @(posedge clk);
      #1;
    end
    pulse_ignored(rand_bits(64), rand_bits(8));
    wait_resp();
    send_req(OP_REM, 1'b1, rand_bits(64), rand_bits(64));
    pulse_ignored(64'h0, 64'h0);  // special would bypass at once if taken
    wait_resp();
    repeat (80) begin
      @(posedge clk);
      #1;
    end
    report_test("busy_behavior");

    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < 4; k++) begin
        run_op(ops[k], 1'b0, edge_a[i], edge_b[i]);
        run_op(ops[k], 1'b1, edge_a[i], edge_b[i]);
      end
    end
    report_test("correction_edges");

    finish_run();
  end

endmodule

// ==== flist.f ====
+incdir+logic
logic/div_pkg.sv
logic/div_request_stage.sv
logic/div_nonrestoring_core.sv
logic/div_result_format.sv
logic/div_unit_top.sv
dv/div_unit_tb.sv

// ==== Bender.yml ====
package:
  name: div_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/div_pkg.sv
      - logic/div_request_stage.sv
      - logic/div_nonrestoring_core.sv
      - logic/div_result_format.sv
      - logic/div_unit_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/div_unit_tb.sv
